// ==== source/axi_bridge_pkg.sv ====
// AXI side definitions for the AXI3 to simple bus bridge
// widths, response codes, single-beat transfer rule and FSM state codes
package axi_bridge_pkg;

   // ----------------------------------------
   // channel widths
   localparam int axi_id_w   = 8;                       // AxID, BID, RID
   localparam int axi_addr_w = 32;                      // byte address
   localparam int axi_data_w = 32;                      // one word per beat
   localparam int axi_len_w  = 4;                       // AXI3 AxLEN
   localparam int axi_size_w = 3;                       // AxSIZE
   localparam int axi_resp_w = 2;                       // BRESP, RRESP

   // ----------------------------------------
   // response codes
   localparam logic [axi_resp_w-1:0] resp_okay   = 2'b00;
   localparam logic [axi_resp_w-1:0] resp_slverr = 2'b10;

   // only single beats of 4 bytes are served
   localparam logic [axi_size_w-1:0] beat_size_word  = 3'b010;
   localparam logic [axi_len_w-1:0]  beat_len_single = 4'h0;

   // ----------------------------------------
   // transaction FSM encoding
   localparam int st_w = 3;
   localparam logic [st_w-1:0] st_idle  = 3'd0;         // waiting for AW or AR
   localparam logic [st_w-1:0] st_wdata = 3'd1;         // waiting for the W beat
   localparam logic [st_w-1:0] st_wbus  = 3'd2;         // write on the simple bus
   localparam logic [st_w-1:0] st_rbus  = 3'd3;         // read on the simple bus
   localparam logic [st_w-1:0] st_resp  = 3'd4;         // B or R pending

   // true for a single 4 byte beat
   function automatic logic is_single_word(input logic [axi_len_w-1:0]  len,
                                           input logic [axi_size_w-1:0] size);
      return (len == beat_len_single) && (size == beat_size_word);
   endfunction

endpackage

// ==== source/sys_bus_pkg.sv ====
// simple strobe bus definitions
// bus widths, register file address map and acknowledge timeout
package sys_bus_pkg;

   // ----------------------------------------
   // bus widths
   localparam int sys_addr_w = 32;                      // byte address
   localparam int sys_data_w = 32;                      // full word transfers

   // ----------------------------------------
   // register file map
   localparam int reg_count = 16;                       // words at 0x00..0x3c
   localparam int reg_idx_w = $clog2(reg_count);        // word index bits

   // register 0 is a read only identifier
   localparam logic [sys_data_w-1:0] reg_id_value = 32'h5b1d_0103;

   // ----------------------------------------
   // acknowledge protection
   localparam int ack_timeout = 32;                     // cycles from acceptance
   localparam int ack_cnt_w   = $clog2(ack_timeout + 1); // holds 0..ack_timeout

endpackage

// ==== source/bridge_fsm.sv ====
// transaction FSM of the AXI to simple bus bridge
// one transaction at a time, write wins over read, sequences bus access and response
`timescale 1ns/100ps

module bridge_fsm (
   input  logic axi,
   input  logic rst,
   input  logic awvalid,
   input  logic arvalid,
   input  logic wvalid,
   input  logic bready,
   input  logic rready,
   input  logic bus_ack,
   input  logic timed_out,
   input  logic xfer_err,
   input  logic resp_busy,
   output logic awready,
   output logic arready,
   output logic wready,
   output logic cap_aw,
   output logic cap_ar,
   output logic cap_w,
   output logic wen,
   output logic ren,
   output logic timer_start,
   output logic timer_done,
   output logic resp_load,
   output logic resp_is_read
);
   import axi_bridge_pkg::*;

   logic [st_w-1:0] state;
   logic [st_w-1:0] state_nxt;
   logic            issue;                            // first cycle of a bus state
   logic            rd_txn;                           // current transaction is a read
   logic            complete;                         // ack, timeout or error

   // ----------------------------------------
   // handshakes
   assign awready = (state == st_idle);
   assign arready = (state == st_idle) && !awvalid;   // write has priority
   assign wready  = (state == st_wdata);

   assign cap_aw = awvalid && awready;
   assign cap_ar = arvalid && arready;
   assign cap_w  = wvalid && wready;

   // bus strobes only for legal, not yet timed out requests
   assign wen = issue && (state == st_wbus) && !xfer_err && !timed_out;
   assign ren = issue && (state == st_rbus) && !xfer_err && !timed_out;

   assign complete = ((state == st_wbus) || (state == st_rbus))
                     && (bus_ack || timed_out || xfer_err);

   assign timer_start  = cap_aw || cap_ar;            // count from acceptance
   assign timer_done   = complete;
   assign resp_load    = complete;
   assign resp_is_read = rd_txn;

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            if (cap_aw)
               state_nxt = st_wdata;
            else if (cap_ar)
               state_nxt = st_rbus;
         end
         st_wdata: if (cap_w) state_nxt = st_wbus;
         st_wbus,
         st_rbus:  if (complete) state_nxt = st_resp;
         st_resp: begin
            // back to idle right after the B or R handshake
            if (resp_busy && (rd_txn ? rready : bready))
               state_nxt = st_idle;
         end
         default:  state_nxt = st_idle;
      endcase
   end

   always_ff @(posedge axi) begin
      if (rst) begin
         state  <= st_idle;
         issue  <= 1'b0;
         rd_txn <= 1'b0;
      end else begin
         state <= state_nxt;
         issue <= cap_w || cap_ar;                     // entering wbus or rbus
         if (cap_aw)
            rd_txn <= 1'b0;
         else if (cap_ar)
            rd_txn <= 1'b1;
      end
   end

endmodule

// ==== source/ack_timer.sv ====
// acknowledge timer
// starts at acceptance, flags a bus access that was never acknowledged
`timescale 1ns/100ps

module ack_timer (
   input  logic axi,
   input  logic rst,
   input  logic start,
   input  logic done,
   output logic timed_out
);
   import sys_bus_pkg::*;

   logic [ack_cnt_w-1:0] cnt;                         // zero when idle

   always_ff @(posedge axi) begin
      if (rst) begin
         cnt <= '0;
      end else begin
         if (done)
            cnt <= '0;                                 // transaction closed
         else if (start)
            cnt <= ack_cnt_w'(1);
         else if ((cnt != '0) && (cnt != ack_cnt_w'(ack_timeout)))
            cnt <= cnt + ack_cnt_w'(1);                // holds at the limit
      end
   end

   // stays high until done clears the count
   assign timed_out = (cnt == ack_cnt_w'(ack_timeout));

endmodule

// ==== source/req_capture.sv ====
// request capture
// holds ID, address, write data and the transfer error flag for the simple bus
`timescale 1ns/100ps

module req_capture (
   input  logic                                  axi,
   input  logic                                  rst,
   input  logic                                  cap_aw,
   input  logic                                  cap_ar,
   input  logic                                  cap_w,
   input  logic [axi_bridge_pkg::axi_id_w-1:0]   awid,
   input  logic [axi_bridge_pkg::axi_addr_w-1:0] awaddr,
   input  logic [axi_bridge_pkg::axi_len_w-1:0]  awlen,
   input  logic [axi_bridge_pkg::axi_size_w-1:0] awsize,
   input  logic [axi_bridge_pkg::axi_id_w-1:0]   arid,
   input  logic [axi_bridge_pkg::axi_addr_w-1:0] araddr,
   input  logic [axi_bridge_pkg::axi_len_w-1:0]  arlen,
   input  logic [axi_bridge_pkg::axi_size_w-1:0] arsize,
   input  logic [axi_bridge_pkg::axi_data_w-1:0] wdata,
   output logic                                  xfer_err,
   output logic [axi_bridge_pkg::axi_id_w-1:0]   txn_id,
   output logic [sys_bus_pkg::sys_addr_w-1:0]    addr,
   output logic [sys_bus_pkg::sys_data_w-1:0]    bus_wdata
);
   import axi_bridge_pkg::*;

   // ----------------------------------------
   // error flag
   always_ff @(posedge axi) begin
      if (rst) begin
         xfer_err <= 1'b0;
      end else begin
         if (cap_aw)
            xfer_err <= !is_single_word(awlen, awsize); // burst or not 4 bytes
         else if (cap_ar)
            xfer_err <= !is_single_word(arlen, arsize);
      end
   end

   // ----------------------------------------
   // payload, stable until the next acceptance
   always_ff @(posedge axi) begin
      if (cap_aw) begin
         txn_id <= awid;
         addr   <= awaddr;
      end else if (cap_ar) begin
         txn_id <= arid;
         addr   <= araddr;
      end
      if (cap_w)
         bus_wdata <= wdata;                           // full word, no strobes
   end

endmodule

// ==== source/resp_gen.sv ====
// response generator
// registers the B or R payload and holds it until the master takes it
`timescale 1ns/100ps

module resp_gen (
   input  logic                                  axi,
   input  logic                                  rst,
   input  logic                                  load,
   input  logic                                  is_read,
   input  logic                                  err,
   input  logic                                  timed_out,
   input  logic [axi_bridge_pkg::axi_id_w-1:0]   txn_id,
   input  logic [sys_bus_pkg::sys_data_w-1:0]    rdata,
   input  logic                                  bready,
   input  logic                                  rready,
   output logic                                  bvalid,
   output logic [axi_bridge_pkg::axi_id_w-1:0]   bid,
   output logic [axi_bridge_pkg::axi_resp_w-1:0] bresp,
   output logic                                  rvalid,
   output logic [axi_bridge_pkg::axi_id_w-1:0]   rid,
   output logic [axi_bridge_pkg::axi_data_w-1:0] rdata_out,
   output logic [axi_bridge_pkg::axi_resp_w-1:0] rresp,
   output logic                                  rlast,
   output logic                                  busy
);
   import axi_bridge_pkg::*;

   logic [axi_resp_w-1:0] code;
   logic                  fail;

   assign fail = err || timed_out;
   assign code = fail ? resp_slverr : resp_okay;
   assign busy = bvalid || rvalid;                     // pending until handshake

   // ----------------------------------------
   // valid flags
   always_ff @(posedge axi) begin
      if (rst) begin
         bvalid <= 1'b0;
         rvalid <= 1'b0;
         rlast  <= 1'b0;
      end else begin
         if (load && !is_read)
            bvalid <= 1'b1;
         else if (bvalid && bready)
            bvalid <= 1'b0;
         if (load && is_read) begin
            rvalid <= 1'b1;
            rlast  <= 1'b1;                            // single beat
         end else if (rvalid && rready) begin
            rvalid <= 1'b0;
            rlast  <= 1'b0;
         end
      end
   end

   // payload, loaded once per transaction
   always_ff @(posedge axi) begin
      if (load && !is_read) begin
         bid   <= txn_id;
         bresp <= code;
      end
      if (load && is_read) begin
         rid       <= txn_id;
         rresp     <= code;
         rdata_out <= fail ? '0 : rdata;               // no stale data on error
      end
   end

endmodule

// ==== source/reg_file.sv ====
// register file on the simple bus
// sixteen words, read only ID at 0x00, no acknowledge above 0x3c
`timescale 1ns/100ps

module reg_file (
   input  logic                               axi,
   input  logic                               rst,
   input  logic [sys_bus_pkg::sys_addr_w-1:0] addr,
   input  logic [sys_bus_pkg::sys_data_w-1:0] wdata,
   input  logic                               wen,
   input  logic                               ren,
   output logic [sys_bus_pkg::sys_data_w-1:0] rdata,
   output logic                               ack
);
   import sys_bus_pkg::*;

   logic [sys_data_w-1:0] regs [1:reg_count-1];        // word 0 is the ID
   logic [reg_idx_w-1:0]  idx;
   logic                  hit;

   // ----------------------------------------
   // address decode
   assign idx = addr[reg_idx_w+1:2];                   // word index
   assign hit = (addr[sys_addr_w-1:reg_idx_w+2] == '0); // 0x00..0x3c only

   // acknowledge one cycle after the strobe
   always_ff @(posedge axi) begin
      if (rst)
         ack <= 1'b0;
      else
         ack <= (wen || ren) && hit;                   // hole never answers
   end

   // ----------------------------------------
   // storage
   always_ff @(posedge axi) begin
      if (wen && hit && (idx != '0))
         regs[idx] <= wdata;                           // writes to the ID are dropped
   end

   // read data lines up with ack
   always_ff @(posedge axi) begin
      if (ren && hit) begin
         if (idx == '0)
            rdata <= reg_id_value;
         else
            rdata <= regs[idx];
      end
   end

endmodule

// ==== source/axi_sys_bridge_top.sv ====
// AXI3 slave bridge to the simple strobe bus
// FSM, timer, capture and response blocks with the register file behind them
`timescale 1ns/100ps

module axi_sys_bridge_top (
   input  logic                                  axi,
   input  logic                                  rst,
   input  logic                                  awvalid,
   output logic                                  awready,
   input  logic [axi_bridge_pkg::axi_id_w-1:0]   awid,
   input  logic [axi_bridge_pkg::axi_addr_w-1:0] awaddr,
   input  logic [axi_bridge_pkg::axi_len_w-1:0]  awlen,
   input  logic [axi_bridge_pkg::axi_size_w-1:0] awsize,
   input  logic                                  wvalid,
   output logic                                  wready,
   input  logic [axi_bridge_pkg::axi_data_w-1:0] wdata,
   output logic                                  bvalid,
   input  logic                                  bready,
   output logic [axi_bridge_pkg::axi_id_w-1:0]   bid,
   output logic [axi_bridge_pkg::axi_resp_w-1:0] bresp,
   input  logic                                  arvalid,
   output logic                                  arready,
   input  logic [axi_bridge_pkg::axi_id_w-1:0]   arid,
   input  logic [axi_bridge_pkg::axi_addr_w-1:0] araddr,
   input  logic [axi_bridge_pkg::axi_len_w-1:0]  arlen,
   input  logic [axi_bridge_pkg::axi_size_w-1:0] arsize,
   output logic                                  rvalid,
   input  logic                                  rready,
   output logic [axi_bridge_pkg::axi_id_w-1:0]   rid,
   output logic [axi_bridge_pkg::axi_data_w-1:0] rdata,
   output logic [axi_bridge_pkg::axi_resp_w-1:0] rresp,
   output logic                                  rlast
);
   import axi_bridge_pkg::*;
   import sys_bus_pkg::*;

   // ----------------------------------------
   // control between the bridge blocks
   logic cap_aw, cap_ar, cap_w;
   logic timer_start, timer_done, timed_out;
   logic resp_load, resp_is_read, resp_busy;
   logic xfer_err;

   // simple bus
   logic                  wen, ren, bus_ack;
   logic [axi_id_w-1:0]   txn_id;
   logic [sys_addr_w-1:0] bus_addr;
   logic [sys_data_w-1:0] bus_wdata;
   logic [sys_data_w-1:0] bus_rdata;

   bridge_fsm u_fsm (
      .axi, .rst, .awvalid, .arvalid, .wvalid, .bready, .rready, .bus_ack, .timed_out,
      .xfer_err, .resp_busy, .awready, .arready, .wready, .cap_aw, .cap_ar, .cap_w,
      .wen, .ren, .timer_start, .timer_done, .resp_load, .resp_is_read
   );

   ack_timer u_timer (
      .axi, .rst, .start(timer_start), .done(timer_done), .timed_out
   );

   req_capture u_capture (
      .axi, .rst, .cap_aw, .cap_ar, .cap_w, .awid, .awaddr, .awlen, .awsize,
      .arid, .araddr, .arlen, .arsize, .wdata, .xfer_err, .txn_id,
      .addr(bus_addr), .bus_wdata
   );

   resp_gen u_resp (
      .axi, .rst, .load(resp_load), .is_read(resp_is_read), .err(xfer_err), .timed_out,
      .txn_id, .rdata(bus_rdata), .bready, .rready, .bvalid, .bid, .bresp,
      .rvalid, .rid, .rdata_out(rdata), .rresp, .rlast, .busy(resp_busy)
   );

   reg_file u_regs (
      .axi, .rst, .addr(bus_addr), .wdata(bus_wdata), .wen, .ren,
      .rdata(bus_rdata), .ack(bus_ack)
   );

endmodule

// ==== tests/bridge_assert.sv ====
// protocol checks bound into the bridge top level
// response hold, single-cycle bus strobes and accept blocking
`timescale 1ns/100ps

module bridge_assert (
   input logic                                  axi,
   input logic                                  rst,
   input logic                                  bvalid,
   input logic                                  bready,
   input logic [axi_bridge_pkg::axi_id_w-1:0]   bid,
   input logic [axi_bridge_pkg::axi_resp_w-1:0] bresp,
   input logic                                  rvalid,
   input logic                                  rready,
   input logic [axi_bridge_pkg::axi_id_w-1:0]   rid,
   input logic [axi_bridge_pkg::axi_data_w-1:0] rdata,
   input logic [axi_bridge_pkg::axi_resp_w-1:0] rresp,
   input logic                                  rlast,
   input logic                                  wen,
   input logic                                  ren,
   input logic                                  awready,
   input logic                                  arready
);
   int unsigned fails = 0;                             // read back by the testbench

   // ----------------------------------------
   // response channels hold until taken
   a_b_hold: assert property (@(posedge axi) disable iff (rst)
      bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp))
   else begin
      fails++;
      $error("B channel changed before its handshake");
   end

   a_r_hold: assert property (@(posedge axi) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(rid) && $stable(rdata)
                            && $stable(rresp) && $stable(rlast))
   else begin
      fails++;
      $error("R channel changed before its handshake");
   end

   // ----------------------------------------
   // simple bus and accept side
   a_one_strobe: assert property (@(posedge axi) disable iff (rst)
      (wen || ren) |=> !wen && !ren)                 // one strobe per access
   else begin
      fails++;
      $error("bus strobe held for more than one cycle");
   end

   a_no_accept: assert property (@(posedge axi) disable iff (rst)
      (bvalid || rvalid) |-> !awready && !arready)   // one transaction at a time
   else begin
      fails++;
      $error("bridge ready for a request while a response is pending");
   end

endmodule

bind axi_sys_bridge_top bridge_assert u_chk (
   .axi, .rst, .bvalid, .bready, .bid, .bresp, .rvalid, .rready, .rid, .rdata,
   .rresp, .rlast, .wen, .ren, .awready, .arready
);

// ==== tests/tb_axi_sys_bridge.sv ====
// testbench for the AXI3 to simple bus bridge
// table-driven AXI master with a shadow model of the register file
`timescale 1ns/100ps

module tb_axi_sys_bridge;
   import axi_bridge_pkg::*;
   import sys_bus_pkg::*;

   localparam int op_wr    = 0;
   localparam int op_rd    = 1;
   localparam int op_wr_rd = 2;                          // AW and AR raised together

   typedef struct {
      int          op;
      logic [31:0] addr;
      logic [3:0]  len;
      logic [2:0]  size;
      logic [7:0]  id;
      logic [31:0] data;
      bit          rnd;                                  // data taken from $random
      logic [1:0]  resp;
      int          stall;                                // cycles of ready held low
   } row_t;

   logic                  axi = 1'b0;
   logic                  rst;
   logic                  awvalid, awready, wvalid, wready, bvalid, bready;
   logic                  arvalid, arready, rvalid, rready, rlast;
   logic [axi_id_w-1:0]   awid, bid, arid, rid;
   logic [axi_addr_w-1:0] awaddr, araddr;
   logic [axi_len_w-1:0]  awlen, arlen;
   logic [axi_size_w-1:0] awsize, arsize;
   logic [axi_data_w-1:0] wdata, rdata;
   logic [axi_resp_w-1:0] bresp, rresp;

   row_t        tbl [$];
   logic [31:0] shadow [reg_count];                      // expected register contents
   integer      seed = 32'h89b8;
   int          errors = 0;

   always #50 axi = ~axi;                                // 100 ns period

   axi_sys_bridge_top DUT (.*);

   function automatic void add_row(int op, logic [31:0] a, logic [3:0] len, logic [2:0] size,
                                   logic [7:0] id, logic [31:0] d, bit rnd, logic [1:0] resp,
                                   int stall);
      row_t r;
      r = '{op, a, len, size, id, d, rnd, resp, stall};
      tbl.push_back(r);
   endfunction

   function automatic logic [31:0] expect_rd(input logic [31:0] a);
      return (a[5:2] == 4'h0) ? reg_id_value : shadow[a[5:2]];   // word 0 is the ID
   endfunction

   task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
      errors++;
      $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
   endtask

   task automatic complain(input string what);
      errors++;
      $display("error at %0t, %s", $time, what);
   endtask

   // ----------------------------------------
   // AXI master, entered and left 1 ns after a rising edge
   task automatic write_txn(input row_t r, input logic [31:0] d);
      logic [axi_id_w-1:0]   got_id;
      logic [axi_resp_w-1:0] got_resp;
      {awaddr, awlen, awsize, awid, wdata} = {r.addr, r.len, r.size, r.id, d};
      awvalid = 1'b1;
      wvalid  = 1'b1;                                    // W offered together with AW
      @(negedge axi);
      while (!awready) @(negedge axi);
      if (arvalid && arready !== 1'b0) mismatch("arready", 1'b0, arready);  // write first
      @(posedge axi);
      #1 awvalid = 1'b0;
      @(negedge axi);
      while (!wready) @(negedge axi);
      @(posedge axi);
      #1 wvalid = 1'b0;
      @(negedge axi);
      while (!bvalid) @(negedge axi);
      if (rvalid) complain("read response came before the write response");
      got_id   = bid;
      got_resp = bresp;
      repeat (r.stall) begin
         @(negedge axi);
         if (!bvalid || bid !== got_id || bresp !== got_resp)
            complain("B channel changed while bready was low");
      end
      @(posedge axi);
      #1 bready = 1'b1;
      @(posedge axi);                                    // B handshake
      #1 bready = 1'b0;
      if (bvalid) complain("bvalid still high after the handshake");
      if (got_id !== r.id) mismatch("bid", r.id, got_id);
      if (got_resp !== r.resp) mismatch("bresp", r.resp, got_resp);
   endtask

   task automatic read_txn(input row_t r, input logic [7:0] id, input logic [31:0] exp_data);
      logic [axi_id_w-1:0]   got_id;
      logic [axi_resp_w-1:0] got_resp;
      logic [axi_data_w-1:0] got_data;
      {araddr, arlen, arsize, arid} = {r.addr, r.len, r.size, id};
      arvalid = 1'b1;
      @(negedge axi);
      while (!arready) @(negedge axi);
      @(posedge axi);
      #1 arvalid = 1'b0;
      @(negedge axi);
      while (!rvalid) @(negedge axi);
      if (!rlast) complain("rlast low on the single read beat");
      got_id   = rid;
      got_resp = rresp;
      got_data = rdata;
      repeat (r.stall) begin
         @(negedge axi);
         if (!rvalid || rid !== got_id || rresp !== got_resp || rdata !== got_data)
            complain("R channel changed while rready was low");
      end
      @(posedge axi);
      #1 rready = 1'b1;
      @(posedge axi);                                    // R handshake
      #1 rready = 1'b0;
      if (rvalid) complain("rvalid still high after the handshake");
      if (got_id !== id) mismatch("rid", id, got_id);
      if (got_resp !== r.resp) mismatch("rresp", r.resp, got_resp);
      if (r.resp == resp_okay && got_data !== exp_data) mismatch("rdata", exp_data, got_data);
   endtask

   // ----------------------------------------
   initial begin
      row_t        r;
      logic [31:0] d;
      rst = 1'b1;
      {awvalid, wvalid, bready, arvalid, rready} = '0;
      {awid, awaddr, awlen, awsize, wdata} = '0;
      {arid, araddr, arlen, arsize} = '0;
      //      op        addr    len   size  id     data           rnd resp         stall
      add_row(op_wr,    32'h04, 4'd0, 3'd2, 8'h11, 32'ha5a5_0004, 0, resp_okay,   0);
      add_row(op_rd,    32'h04, 4'd0, 3'd2, 8'h12, 32'h0,         0, resp_okay,   0);
      add_row(op_wr,    32'h3c, 4'd0, 3'd2, 8'h21, 32'h0,         1, resp_okay,   4);
      add_row(op_rd,    32'h3c, 4'd0, 3'd2, 8'h22, 32'h0,         0, resp_okay,   3);
      add_row(op_wr,    32'h00, 4'd0, 3'd2, 8'h31, 32'hffff_ffff, 0, resp_okay,   0);
      add_row(op_rd,    32'h00, 4'd0, 3'd2, 8'h32, 32'h0,         0, resp_okay,   0);
      add_row(op_wr,    32'h08, 4'd0, 3'd2, 8'h41, 32'h0,         1, resp_okay,   0);
      add_row(op_wr,    32'h08, 4'd3, 3'd2, 8'h42, 32'hdead_beef, 0, resp_slverr, 0);
      add_row(op_wr,    32'h08, 4'd0, 3'd1, 8'h43, 32'h1234_5678, 0, resp_slverr, 0);
      add_row(op_rd,    32'h08, 4'd1, 3'd2, 8'h44, 32'h0,         0, resp_slverr, 0);
      add_row(op_rd,    32'h08, 4'd0, 3'd2, 8'h45, 32'h0,         0, resp_okay,   0);
      add_row(op_wr,    32'h40, 4'd0, 3'd2, 8'h51, 32'h0bad_0040, 0, resp_slverr, 2);
      add_row(op_rd,    32'h80, 4'd0, 3'd2, 8'h52, 32'h0,         0, resp_slverr, 0);
      add_row(op_wr,    32'h10, 4'd0, 3'd2, 8'h53, 32'h0,         1, resp_okay,   0);
      add_row(op_rd,    32'h10, 4'd0, 3'd2, 8'h54, 32'h0,         0, resp_okay,   0);
      add_row(op_wr_rd, 32'h0c, 4'd0, 3'd2, 8'h61, 32'h0,         1, resp_okay,   0);
      add_row(op_rd,    32'h0c, 4'd0, 3'd2, 8'h63, 32'h0,         0, resp_okay,   0);

      repeat (4) @(posedge axi);
      #1 rst = 1'b0;
      @(negedge axi);
      if (bvalid !== 1'b0) mismatch("bvalid", 1'b0, bvalid);
      if (rvalid !== 1'b0) mismatch("rvalid", 1'b0, rvalid);
      if (rlast !== 1'b0) mismatch("rlast", 1'b0, rlast);
      if (wready !== 1'b0) mismatch("wready", 1'b0, wready);
      if (awready !== 1'b1) mismatch("awready", 1'b1, awready);
      if (arready !== 1'b1) mismatch("arready", 1'b1, arready);  // idle, no awvalid
      @(posedge axi);
      #1;

      foreach (tbl[i]) begin
         r = tbl[i];
         d = r.rnd ? $random(seed) : r.data;
         if (r.op == op_rd) begin
            read_txn(r, r.id, expect_rd(r.addr));
         end else begin
            if (r.op == op_wr_rd) begin
               {araddr, arlen, arsize, arid} = {r.addr, r.len, r.size, r.id + 8'h01};
               arvalid = 1'b1;                           // same cycle as awvalid
            end
            write_txn(r, d);
            if (r.resp == resp_okay && r.addr[5:2] != 4'h0)
               shadow[r.addr[5:2]] = d;                  // ID word drops writes
            if (r.op == op_wr_rd)
               read_txn(r, r.id + 8'h01, expect_rd(r.addr));
         end
      end

      errors += DUT.u_chk.fails;
      $display("bridge run finished with %0d errors", errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

   // watchdog, 60 cycles per row plus reset
   initial begin
      #1;
      repeat (tbl.size() * 60 + 4) @(posedge axi);
      $display("watchdog expired, the bridge did not finish the table in time");
      $display("TESTS FAILED");
      $finish;
   end

endmodule

// ==== list.f ====
source/axi_bridge_pkg.sv
source/sys_bus_pkg.sv
source/bridge_fsm.sv
source/ack_timer.sv
source/req_capture.sv
source/resp_gen.sv
source/reg_file.sv
source/axi_sys_bridge_top.sv
tests/bridge_assert.sv
tests/tb_axi_sys_bridge.sv

// ==== Bender.yml ====
package:
  name: axi_sys_bridge

sources:
  - source/axi_bridge_pkg.sv
  - source/sys_bus_pkg.sv
  - source/bridge_fsm.sv
  - source/ack_timer.sv
  - source/req_capture.sv
  - source/resp_gen.sv
  - source/reg_file.sv
  - source/axi_sys_bridge_top.sv
  - target: test
    files:
      - tests/bridge_assert.sv
      - tests/tb_axi_sys_bridge.sv
